// File: include/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// bus and memory geometry
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_RAM_WORDS 1024
`define SOC_ROM_WORDS 256

// region codes, taken from address bits 31..28
`define SOC_REGION_ROM_ALIAS 0
`define SOC_REGION_ROM 1
`define SOC_REGION_RAM 3
`define SOC_REGION_IO 4

// word offsets inside the io block
`define SOC_IO_LED 0
`define SOC_IO_HEX 1
`define SOC_IO_CTRL 2
`define SOC_IO_FAULTS 3

`endif

// File: design/bus_pkg.sv
`include "soc_config.svh"

package bus_pkg;

  // byte address as issued by the master
  typedef logic [`SOC_ADDR_W-1:0] addr_t;

  typedef logic [`SOC_DATA_W-1:0] data_t;

  // one enable per byte lane
  typedef logic [`SOC_DATA_W/8-1:0] be_t;

  // top nibble of the address selects the target
  typedef logic [3:0] region_t;

  // boot image pattern: inverted index on top, index below
  function automatic data_t rom_word(input int unsigned index);
    logic [15:0] low;
    low = index[15:0];
    return {~low, low};
  endfunction

endpackage

// File: design/periph_pkg.sv
package periph_pkg;

  typedef logic [17:0] led_t;
  typedef logic [31:0] hex_t;

  // segments g..a, a zero lights the segment
  typedef logic [6:0] seg_t;

  function automatic seg_t seg_encode(input logic [3:0] digit);
    seg_t seg;
    case (digit)
      4'h0: seg = 7'h40;
      4'h1: seg = 7'h79;
      4'h2: seg = 7'h24;
      4'h3: seg = 7'h30;
      4'h4: seg = 7'h19;
      4'h5: seg = 7'h12;
      4'h6: seg = 7'h02;
      4'h7: seg = 7'h78;
      4'h8: seg = 7'h00;
      4'h9: seg = 7'h10;
      4'ha: seg = 7'h08;
      4'hb: seg = 7'h03;
      4'hc: seg = 7'h46;
      4'hd: seg = 7'h21;
      4'he: seg = 7'h06;
      default: seg = 7'h0e;
    endcase
    return seg;
  endfunction

endpackage

// File: design/bus_if.sv
`timescale 1ns/1ps

interface bus_if
  import bus_pkg::*;
();

  // single-cycle strobes, never both at once
  logic  read;
  logic  write;
  // word index inside the target, region bits already stripped
  addr_t addr;
  data_t wdata;
  be_t   be;
  // registered by the target one edge after the strobe
  data_t rdata;

  modport target (
    input  read, write, addr, wdata, be,
    output rdata
  );

  modport decoder (
    output read, write, addr, wdata, be,
    input  rdata
  );

endinterface

// File: design/address_decoder.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module address_decoder
  import bus_pkg::*;
(
  input  logic   clock_50,
  input  logic   rst_n,
  input  logic   read,
  input  logic   write,
  input  addr_t  address,
  input  data_t  writedata,
  input  be_t    byteenable,
  input  logic   map,
  bus_if.decoder rom_bus,
  bus_if.decoder ram_bus,
  bus_if.decoder io_bus,
  output data_t  readdata,
  output logic   rvalid,
  output logic   fault
);

  region_t region;
  region_t target;
  logic    claimed;
  addr_t   word_addr;
  // stage 1: region of the read whose data the targets return next
  region_t sel_q;
  logic    rd_q;
  data_t   merged;

  assign region = address[`SOC_ADDR_W-1 -: 4];

  // region 0 aliases the ROM, or the RAM once the map bit is set
  always_comb begin
    target = region;
    if (region == `SOC_REGION_ROM_ALIAS) begin
      target = map ? region_t'(`SOC_REGION_RAM) : region_t'(`SOC_REGION_ROM);
    end
  end

  assign claimed = (target == `SOC_REGION_ROM) || (target == `SOC_REGION_RAM) ||
                   (target == `SOC_REGION_IO);

  assign word_addr = addr_t'(address[`SOC_ADDR_W-5:2]);

  // strobes go to the selected target only
  assign rom_bus.read  = read && (target == `SOC_REGION_ROM);
  assign rom_bus.write = write && (target == `SOC_REGION_ROM);
  assign ram_bus.read  = read && (target == `SOC_REGION_RAM);
  assign ram_bus.write = write && (target == `SOC_REGION_RAM);
  assign io_bus.read   = read && (target == `SOC_REGION_IO);
  assign io_bus.write  = write && (target == `SOC_REGION_IO);

  assign rom_bus.addr  = word_addr;
  assign ram_bus.addr  = word_addr;
  assign io_bus.addr   = word_addr;
  assign rom_bus.wdata = writedata;
  assign ram_bus.wdata = writedata;
  assign io_bus.wdata  = writedata;
  assign rom_bus.be    = byteenable;
  assign ram_bus.be    = byteenable;
  assign io_bus.be     = byteenable;

  // unclaimed reads fall through to zero
  always_comb begin
    case (sel_q)
      `SOC_REGION_ROM: merged = rom_bus.rdata;
      `SOC_REGION_RAM: merged = ram_bus.rdata;
      `SOC_REGION_IO:  merged = io_bus.rdata;
      default:         merged = '0;
    endcase
  end

  always_ff @(posedge clock_50) begin
    sel_q <= target;
    if (rd_q) begin
      readdata <= merged;
    end
  end

  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      rd_q   <= 1'b0;
      rvalid <= 1'b0;
      fault  <= 1'b0;
    end else begin
      rd_q   <= read;
      rvalid <= rd_q;
      fault  <= (read || write) && !claimed;
    end
  end

endmodule

// File: design/boot_rom.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module boot_rom
  import bus_pkg::*;
(
  input  logic  clock_50,
  bus_if.target bus
);

  localparam int ROM_AW = $clog2(`SOC_ROM_WORDS);

  data_t             rom_mem [0:`SOC_ROM_WORDS-1];
  logic [ROM_AW-1:0] index;

  // image is fixed at elaboration, no load path
  initial begin
    for (int i = 0; i < `SOC_ROM_WORDS; i++) begin
      rom_mem[i] = rom_word(i);
    end
  end

  // upper word bits are dropped, so the image repeats
  assign index = bus.addr[ROM_AW-1:0];

  always_ff @(posedge clock_50) begin
    if (bus.read) begin
      bus.rdata <= rom_mem[index];
    end
  end

endmodule

// File: design/scratch_ram.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module scratch_ram
  import bus_pkg::*;
(
  input  logic  clock_50,
  bus_if.target bus
);

  localparam int RAM_AW = $clog2(`SOC_RAM_WORDS);
  localparam int LANES  = `SOC_DATA_W / 8;

  data_t             ram_mem [0:`SOC_RAM_WORDS-1];
  logic [RAM_AW-1:0] index;

  // wraps modulo the depth
  assign index = bus.addr[RAM_AW-1:0];

  // byte lanes written independently
  always_ff @(posedge clock_50) begin
    if (bus.write) begin
      for (int b = 0; b < LANES; b++) begin
        if (bus.be[b]) begin
          ram_mem[index][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // registered read port, one edge after the strobe
  always_ff @(posedge clock_50) begin
    if (bus.read) begin
      bus.rdata <= ram_mem[index];
    end
  end

endmodule

// File: design/io_regs.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module io_regs
  import bus_pkg::*;
  import periph_pkg::*;
(
  input  logic  clock_50,
  input  logic  rst_n,
  bus_if.target bus,
  input  logic  fault,
  output logic  map,
  output led_t  ledr,
  output hex_t  hex_value
);

  led_t  led_q;
  hex_t  hex_q;
  data_t ctrl_q;
  data_t fault_cnt;

  // replace only the enabled byte lanes of cur
  function automatic data_t apply_be(input data_t cur, input data_t nxt, input be_t be);
    data_t res;
    res = cur;
    for (int b = 0; b < $bits(be_t); b++) begin
      if (be[b]) begin
        res[8*b +: 8] = nxt[8*b +: 8];
      end
    end
    return res;
  endfunction

  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      led_q     <= '0;
      hex_q     <= '0;
      ctrl_q    <= '0;
      fault_cnt <= '0;
    end else begin
      if (bus.write) begin
        case (bus.addr)
          `SOC_IO_LED:  led_q  <= led_t'(apply_be(data_t'(led_q), bus.wdata, bus.be));
          `SOC_IO_HEX:  hex_q  <= hex_t'(apply_be(data_t'(hex_q), bus.wdata, bus.be));
          `SOC_IO_CTRL: ctrl_q <= apply_be(ctrl_q, bus.wdata, bus.be);
          // the fault counter is read only
          default: ;
        endcase
      end
      // holds at all ones instead of wrapping
      if (fault && (fault_cnt != '1)) begin
        fault_cnt <= fault_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clock_50) begin
    if (bus.read) begin
      case (bus.addr)
        `SOC_IO_LED:    bus.rdata <= data_t'(led_q);
        `SOC_IO_HEX:    bus.rdata <= data_t'(hex_q);
        `SOC_IO_CTRL:   bus.rdata <= ctrl_q;
        `SOC_IO_FAULTS: bus.rdata <= fault_cnt;
        default:        bus.rdata <= '0;
      endcase
    end
  end

  assign map       = ctrl_q[0];
  assign ledr      = led_q;
  assign hex_value = hex_q;

endmodule

// File: design/hex_display.sv
`timescale 1ns/1ps

module hex_display
  import periph_pkg::*;
(
  input  hex_t hex_value,
  output seg_t hex0,
  output seg_t hex1,
  output seg_t hex2,
  output seg_t hex3,
  output seg_t hex4,
  output seg_t hex5,
  output seg_t hex6,
  output seg_t hex7
);

  // hex0 is the rightmost digit, least significant nibble
  assign hex0 = seg_encode(hex_value[3:0]);
  assign hex1 = seg_encode(hex_value[7:4]);
  assign hex2 = seg_encode(hex_value[11:8]);
  assign hex3 = seg_encode(hex_value[15:12]);
  assign hex4 = seg_encode(hex_value[19:16]);
  assign hex5 = seg_encode(hex_value[23:20]);
  assign hex6 = seg_encode(hex_value[27:24]);
  assign hex7 = seg_encode(hex_value[31:28]);

endmodule

// File: design/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top
  import bus_pkg::*;
  import periph_pkg::*;
(
  input  logic  clock_50,
  input  logic  rst_n,
  input  logic  read,
  input  logic  write,
  input  addr_t address,
  input  data_t writedata,
  input  be_t   byteenable,
  output data_t readdata,
  output logic  rvalid,
  output logic  fault,
  output led_t  ledr,
  output seg_t  hex0,
  output seg_t  hex1,
  output seg_t  hex2,
  output seg_t  hex3,
  output seg_t  hex4,
  output seg_t  hex5,
  output seg_t  hex6,
  output seg_t  hex7
);

  // one bus per target
  bus_if rom_bus ();
  bus_if ram_bus ();
  bus_if io_bus ();

  logic map;
  hex_t hex_value;

  address_decoder decoder0 (
    .clock_50   (clock_50),
    .rst_n      (rst_n),
    .read       (read),
    .write      (write),
    .address    (address),
    .writedata  (writedata),
    .byteenable (byteenable),
    .map        (map),
    .rom_bus    (rom_bus.decoder),
    .ram_bus    (ram_bus.decoder),
    .io_bus     (io_bus.decoder),
    .readdata   (readdata),
    .rvalid     (rvalid),
    .fault      (fault)
  );

  boot_rom rom0 (
    .clock_50 (clock_50),
    .bus      (rom_bus.target)
  );

  scratch_ram ram0 (
    .clock_50 (clock_50),
    .bus      (ram_bus.target)
  );

  // the map bit loops back into the decoder
  io_regs io0 (
    .clock_50  (clock_50),
    .rst_n     (rst_n),
    .bus       (io_bus.target),
    .fault     (fault),
    .map       (map),
    .ledr      (ledr),
    .hex_value (hex_value)
  );

  hex_display disp0 (
    .hex_value (hex_value),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3),
    .hex4      (hex4),
    .hex5      (hex5),
    .hex6      (hex6),
    .hex7      (hex7)
  );

endmodule

// File: tests/soc_bus_tb.sv
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_bus_tb
  import bus_pkg::*;
  import periph_pkg::*;
();

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 10;
  localparam int ROM_READS      = 16;
  localparam int FILL_WORDS     = 32;
  localparam int RANDOM_ROUNDS  = 40;
  // requests of the map, register and fault phases rounded up
  localparam int FIXED_REQUESTS = 64;
  localparam int REQUEST_COUNT  = 2 * ROM_READS + FILL_WORDS + 3 * RANDOM_ROUNDS +
                                  FIXED_REQUESTS;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * REQUEST_COUNT + 100;
  localparam addr_t IO_BASE     = 32'h4000_0000;

  logic  clock_50;
  logic  rst_n;
  logic  read;
  logic  write;
  addr_t address;
  data_t writedata;
  be_t   byteenable;
  data_t readdata;
  logic  rvalid;
  logic  fault;
  led_t  ledr;
  seg_t  hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7;
  logic [55:0] hex_bus;

  // reference model state
  data_t shadow_ram [0:`SOC_RAM_WORDS-1];
  led_t  shadow_led;
  hex_t  shadow_hex;
  data_t shadow_ctrl;
  data_t shadow_faults;

  logic [31:0] lfsr_state = 32'h609e85ac;
  int    cycle = 0;
  int    fault_seen = 0;
  int    fault_expected = 0;
  data_t exp_data_q [$];
  int    exp_stamp_q [$];

  soc_bus_top dut0 (
    .clock_50   (clock_50),
    .rst_n      (rst_n),
    .read       (read),
    .write      (write),
    .address    (address),
    .writedata  (writedata),
    .byteenable (byteenable),
    .readdata   (readdata),
    .rvalid     (rvalid),
    .fault      (fault),
    .ledr       (ledr),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .hex4       (hex4),
    .hex5       (hex5),
    .hex6       (hex6),
    .hex7       (hex7)
  );

  assign hex_bus = {hex7, hex6, hex5, hex4, hex3, hex2, hex1, hex0};

  initial begin
    clock_50 = 1'b0;
    forever #(CLK_PERIOD / 2) clock_50 = ~clock_50;
  end

  always @(posedge clock_50) begin
    cycle <= cycle + 1;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    logic        lsb;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ 32'hd000_0001;
      end
      value = {value[30:0], lsb};
    end
    return value;
  endfunction

  // active-low segments g..a for one hex digit
  function automatic logic [6:0] segments_for(input logic [3:0] digit);
    case (digit)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'ha: return 7'h08;
      4'hb: return 7'h03;
      4'hc: return 7'h46;
      4'hd: return 7'h21;
      4'he: return 7'h06;
      default: return 7'h0e;
    endcase
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t nxt, input be_t be);
    data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = nxt[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic region_t resolve_region(input addr_t a, input logic map_bit);
    region_t r;
    r = a[31:28];
    if (r == `SOC_REGION_ROM_ALIAS) begin
      r = map_bit ? region_t'(`SOC_REGION_RAM) : region_t'(`SOC_REGION_ROM);
    end
    return r;
  endfunction

  function automatic logic is_claimed(input region_t r);
    return (r == `SOC_REGION_ROM) || (r == `SOC_REGION_RAM) || (r == `SOC_REGION_IO);
  endfunction

  // predicted read data for the current model state
  function automatic data_t expected_read(input addr_t a);
    logic [25:0] word;
    logic [15:0] low;
    word = a[27:2];
    case (resolve_region(a, shadow_ctrl[0]))
      `SOC_REGION_ROM: begin
        low = {8'h00, word[7:0]};
        return {~low, low};
      end
      `SOC_REGION_RAM: return shadow_ram[word[9:0]];
      `SOC_REGION_IO: begin
        case (word)
          `SOC_IO_LED:    return data_t'(shadow_led);
          `SOC_IO_HEX:    return data_t'(shadow_hex);
          `SOC_IO_CTRL:   return shadow_ctrl;
          `SOC_IO_FAULTS: return shadow_faults;
          default:        return '0;
        endcase
      end
      default: return '0;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic note_fault();
    shadow_faults = shadow_faults + 1;
    fault_expected = fault_expected + 1;
  endtask

  task automatic issue_write(input addr_t a, input data_t d, input be_t be);
    region_t r;
    @(posedge clock_50);
    read       <= 1'b0;
    write      <= 1'b1;
    address    <= a;
    writedata  <= d;
    byteenable <= be;
    r = resolve_region(a, shadow_ctrl[0]);
    if (r == `SOC_REGION_RAM) begin
      shadow_ram[a[11:2]] = merge_bytes(shadow_ram[a[11:2]], d, be);
    end else if (r == `SOC_REGION_IO) begin
      case (a[27:2])
        `SOC_IO_LED:  shadow_led = led_t'(merge_bytes(data_t'(shadow_led), d, be));
        `SOC_IO_HEX:  shadow_hex = hex_t'(merge_bytes(data_t'(shadow_hex), d, be));
        `SOC_IO_CTRL: shadow_ctrl = merge_bytes(shadow_ctrl, d, be);
        default: ;
      endcase
    end else if (!is_claimed(r)) begin
      note_fault();
    end
  endtask

  task automatic issue_read(input addr_t a);
    @(posedge clock_50);
    read    <= 1'b1;
    write   <= 1'b0;
    address <= a;
    // cycle still holds the count before this edge
    exp_stamp_q.push_back(cycle + 1);
    exp_data_q.push_back(expected_read(a));
    if (!is_claimed(resolve_region(a, shadow_ctrl[0]))) begin
      note_fault();
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clock_50);
      read  <= 1'b0;
      write <= 1'b0;
    end
  endtask

  // response checker sampled mid-cycle
  always @(negedge clock_50) begin
    data_t want;
    int    stamp;
    if (rst_n) begin
      if (fault) begin
        fault_seen = fault_seen + 1;
      end
      if (rvalid) begin
        if (exp_data_q.size() == 0) begin
          $display("rvalid went high at %0t with no read outstanding", $time);
          $display("TESTBENCH FAILED");
          $fatal(1, "unexpected rvalid");
        end else begin
          want  = exp_data_q.pop_front();
          stamp = exp_stamp_q.pop_front();
          check_value("readdata", readdata, want);
          check_value("read latency", cycle - stamp, 2);
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, reads still outstanding", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    addr_t       a;
    be_t         be;
    logic [7:0]  idx;
    logic [4:0]  w;
    logic [17:0] hi18;
    logic [15:0] hi16;
    rst_n         = 1'b0;
    read          = 1'b0;
    write         = 1'b0;
    address       = '0;
    writedata     = '0;
    byteenable    = '0;
    shadow_led    = '0;
    shadow_hex    = '0;
    shadow_ctrl   = '0;
    shadow_faults = '0;
    repeat (RESET_CYCLES) @(posedge clock_50);
    rst_n <= 1'b1;

    @(negedge clock_50);
    check_value("rvalid after reset", rvalid, 0);
    check_value("fault after reset", fault, 0);
    check_value("ledr after reset", ledr, 0);
    for (int n = 0; n < 8; n++) begin
      check_value("hex digit after reset", hex_bus[7*n +: 7], segments_for(4'h0));
    end

    // ROM direct with wrapped upper bits and then through the alias
    for (int i = 0; i < ROM_READS; i++) begin
      idx  = random_bits(8);
      hi18 = random_bits(18);
      issue_read({4'h1, hi18, idx, 2'b00});
    end
    for (int i = 0; i < ROM_READS; i++) begin
      idx = random_bits(8);
      issue_read({4'h0, 18'h0, idx, 2'b00});
    end
    issue_write(32'h1000_0010, 32'hdead_beef, 4'hf);
    issue_read(32'h1000_0010);

    for (int i = 0; i < FILL_WORDS; i++) begin
      issue_write({4'h3, 21'h0, i[4:0], 2'b00}, random_bits(32), 4'hf);
    end
    for (int r = 0; r < RANDOM_ROUNDS; r++) begin
      w    = random_bits(5);
      hi16 = random_bits(16);
      be   = random_bits(4);
      a    = {4'h3, hi16, 5'h00, w, 2'b00};
      issue_write(a, random_bits(32), be);
      issue_read(a);
      w = random_bits(5);
      issue_read({4'h3, 21'h0, w, 2'b00});
    end

    // region 0 follows the map bit
    issue_write(IO_BASE + 8, 32'h1, 4'h1);
    for (int i = 0; i < 8; i++) begin
      issue_read({4'h0, 21'h0, i[4:0], 2'b00});
    end
    issue_read(IO_BASE + 8);
    issue_write(IO_BASE + 8, 32'h0, 4'hf);
    for (int i = 0; i < 4; i++) begin
      issue_read({4'h0, 21'h0, i[4:0], 2'b00});
    end

    issue_write(IO_BASE, random_bits(32), 4'hf);
    issue_write(IO_BASE + 4, random_bits(32), 4'hf);
    issue_write(IO_BASE + 4, random_bits(32), 4'h4);
    issue_read(IO_BASE);
    issue_read(IO_BASE + 4);
    idle(2);
    @(negedge clock_50);
    check_value("ledr", ledr, shadow_led);
    for (int n = 0; n < 8; n++) begin
      check_value("hex digit", hex_bus[7*n +: 7], segments_for(shadow_hex[4*n +: 4]));
    end

    // unclaimed regions
    issue_read(32'h2000_0000);
    issue_write(32'h5000_0040, random_bits(32), 4'hf);
    issue_read(32'ha000_0100);
    issue_write(32'hf000_0000, 32'h0, 4'hf);
    issue_read(32'h7000_0004);
    // counter lags the fault pulse by one edge
    idle(3);
    issue_read(IO_BASE + 12);
    issue_read(IO_BASE + 16);
    idle(1);

    while (exp_data_q.size() != 0) begin
      @(negedge clock_50);
    end
    idle(2);
    check_value("fault pulses", fault_seen, fault_expected);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+include
design/bus_pkg.sv
design/periph_pkg.sv
design/bus_if.sv
design/address_decoder.sv
design/boot_rom.sv
design/scratch_ram.sv
design/io_regs.sv
design/hex_display.sv
design/soc_bus_top.sv
tests/soc_bus_tb.sv

// File: Bender.yml
package:
  name: soc_bus

export_include_dirs:
  - include

sources:
  - design/bus_pkg.sv
  - design/periph_pkg.sv
  - design/bus_if.sv
  - design/address_decoder.sv
  - design/boot_rom.sv
  - design/scratch_ram.sv
  - design/io_regs.sv
  - design/hex_display.sv
  - design/soc_bus_top.sv
  - target: simulation
    files:
      - tests/soc_bus_tb.sv
